/* project.f */
logic/bus_pkg.sv
logic/soc_map_pkg.sv
logic/rst_sync.sv
logic/bus_decoder.sv
logic/sim_ram.sv
logic/uart_port.sv
logic/timer_regs.sv
logic/timer_counter.sv
logic/soc_periph_top.sv
sim/tb_soc_periph.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_soc_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

    localparam int RAM_WORDS    = 256;
    localparam int TIME_W       = 32;
    localparam int NUM_ENTRIES  = 30;
    localparam int CYCLE_LIMIT  = NUM_ENTRIES * 8 + 200;
    localparam int ACK_LATENCY  = 2;     // Edges from req sampled to ack seen
    localparam int ACK_WAIT_MAX = 16;

    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
    } txn_t;

    logic                   clock;
    logic                   rst_n;
    logic                   host_req;
    bus_pkg::bus_req_t      host_req_data;
    logic                   uart_rx_valid;
    logic [7:0]             uart_rx_ch;
    wire                    host_ack;
    wire bus_pkg::bus_rsp_t host_rsp;
    wire                    uart_tx_valid;
    wire [7:0]              uart_tx_ch;
    wire                    timer_irq;

    txn_t        table_q[$];
    string       name_q[$];
    logic [31:0] ram_model [RAM_WORDS];
    integer      seed;
    int          next_idx;
    int          cycle_count = 0;
    int          tx_count = 0;
    logic [7:0]  tx_last = 8'h00;

    soc_periph_top #(
        .RAM_WORDS (RAM_WORDS),
        .TIME_W    (TIME_W)
    ) i_dut (
        .clock           (clock),
        .rst_n_i         (rst_n),
        .host_req_i      (host_req),
        .host_req_data_i (host_req_data),
        .uart_rx_valid_i (uart_rx_valid),
        .uart_rx_ch_i    (uart_rx_ch),
        .host_ack_o      (host_ack),
        .host_rsp_o      (host_rsp),
        .uart_tx_valid_o (uart_tx_valid),
        .uart_tx_ch_o    (uart_tx_ch),
        .timer_irq_o     (timer_irq)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Checks failed");
            $fatal(1, "Run aborted on timeout");
        end
    end

    // Transmit pulses seen by the UART peer
    always @(negedge clock) begin
        if (uart_tx_valid) begin
            tx_count <= tx_count + 1;
            tx_last  <= uart_tx_ch;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic bus_transfer(input string name, input logic [31:0] addr, input logic we,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int lat;
        host_req_data.addr  = addr;
        host_req_data.wdata = wdata;
        host_req_data.we    = we;
        host_req            = 1'b1;
        lat = -1;                                 // First edge only samples req
        do begin
            @(negedge clock);
            lat++;
        end while (!host_ack && lat < ACK_WAIT_MAX);
        check_value({name, " ack rise"}, ACK_LATENCY, 32'(lat));
        rdata    = host_rsp.rdata;
        err      = host_rsp.err;
        host_req = 1'b0;
        lat = -1;
        do begin
            @(negedge clock);
            lat++;
        end while (host_ack && lat < ACK_WAIT_MAX);
        check_value({name, " ack fall"}, ACK_LATENCY, 32'(lat));
    endtask

    task automatic add_entry(input string name, input logic [31:0] addr, input logic we,
                             input logic [31:0] wdata, input logic [31:0] exp_rdata,
                             input logic exp_err);
        txn_t t;
        t.addr      = addr;
        t.we        = we;
        t.wdata     = wdata;
        t.exp_rdata = exp_rdata;
        t.exp_err   = exp_err;
        table_q.push_back(t);
        name_q.push_back(name);
    endtask

    // Runs every entry added since the last call
    task automatic run_table();
        logic [31:0] rdata;
        logic        err;
        txn_t        t;
        while (next_idx < table_q.size()) begin
            t = table_q[next_idx];
            bus_transfer(name_q[next_idx], t.addr, t.we, t.wdata, rdata, err);
            check_value({name_q[next_idx], " err"}, 32'(t.exp_err), 32'(err));
            if (!t.we) begin
                check_value(name_q[next_idx], t.exp_rdata, rdata);
            end
            next_idx++;
        end
    endtask

    function automatic logic [31:0] ctrl_word(input logic en, input logic irqen);
        logic [31:0] w;
        w = '0;
        w[soc_map_pkg::TMR_CTRL_EN_BIT]    = en;
        w[soc_map_pkg::TMR_CTRL_IRQEN_BIT] = irqen;
        return w;
    endfunction

    initial begin
        int          words[6];
        logic [31:0] data;
        logic [31:0] time_a;
        logic [31:0] time_b;
        logic [31:0] uart_data;
        logic [31:0] uart_stat;
        logic [31:0] tmr_ctrl;
        logic [31:0] tmr_cmp;
        logic [31:0] tmr_time;
        logic        err;

        seed          = 59128;
        clock         = 1'b0;
        rst_n         = 1'b0;
        host_req      = 1'b0;
        host_req_data = '0;
        uart_rx_valid = 1'b0;
        uart_rx_ch    = 8'h00;
        next_idx      = 0;
        words         = '{0, 1, 7, 40, RAM_WORDS - 1, 7 + RAM_WORDS};    // Last aliases word 7
        uart_data     = soc_map_pkg::UART_BASE + soc_map_pkg::UART_DATA_OFS;
        uart_stat     = soc_map_pkg::UART_BASE + soc_map_pkg::UART_STAT_OFS;
        tmr_ctrl      = soc_map_pkg::TIMER_BASE + soc_map_pkg::TMR_CTRL_OFS;
        tmr_cmp       = soc_map_pkg::TIMER_BASE + soc_map_pkg::TMR_CMP_OFS;
        tmr_time      = soc_map_pkg::TIMER_BASE + soc_map_pkg::TMR_TIME_OFS;

        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        repeat (3) @(negedge clock);    // Synchronized release inside the DUT

        foreach (words[i]) begin
            data = $random(seed);
            ram_model[words[i] % RAM_WORDS] = data;
            add_entry($sformatf("ram wr %0d", words[i]),
                      soc_map_pkg::RAM_BASE + 32'(words[i] * 4), 1'b1, data, 32'h0, 1'b0);
        end
        foreach (words[i]) begin
            add_entry($sformatf("ram rd %0d", words[i]),
                      soc_map_pkg::RAM_BASE + 32'(words[i] * 4), 1'b0, 32'h0,
                      ram_model[words[i] % RAM_WORDS], 1'b0);
        end
        add_entry("unmapped rd", 32'h4000_0010, 1'b0, 32'h0, 32'h0, 1'b1);
        add_entry("unmapped wr", 32'h4000_0000, 1'b1, 32'hDEAD_BEEF, 32'h0, 1'b1);
        add_entry("uart tx wr", uart_data, 1'b1, 32'h1234_56A5, 32'h0, 1'b0);
        run_table();

        repeat (2) @(negedge clock);
        check_value("uart tx pulses", 32'd1, 32'(tx_count));
        check_value("uart tx char", 32'h0000_00A5, 32'(tx_last));

        uart_rx_valid = 1'b1;
        uart_rx_ch    = 8'h3C;
        @(negedge clock);
        uart_rx_valid = 1'b0;
        add_entry("uart stat full", uart_stat, 1'b0, 32'h0, 32'h1, 1'b0);
        add_entry("uart rx char", uart_data, 1'b0, 32'h0, 32'h3C, 1'b0);
        add_entry("uart stat empty", uart_stat, 1'b0, 32'h0, 32'h0, 1'b0);
        run_table();

        uart_rx_valid = 1'b1;
        uart_rx_ch    = 8'h51;
        @(negedge clock);
        uart_rx_ch    = 8'h7E;          // Arrives while the first is still held
        @(negedge clock);
        uart_rx_valid = 1'b0;
        add_entry("uart stat overrun", uart_stat, 1'b0, 32'h0, 32'h3, 1'b0);
        add_entry("uart rx first", uart_data, 1'b0, 32'h0, 32'h51, 1'b0);
        add_entry("uart stat cleared", uart_stat, 1'b0, 32'h0, 32'h0, 1'b0);
        add_entry("uart bad ofs", soc_map_pkg::UART_BASE + 32'h8, 1'b0, 32'h0, 32'h0, 1'b1);

        add_entry("tmr time wr", tmr_time, 1'b1, 32'h1234, 32'h0, 1'b1);
        add_entry("tmr cmp reset", tmr_cmp, 1'b0, 32'h0, 32'hFFFF_FFFF, 1'b0);
        add_entry("tmr enable", tmr_ctrl, 1'b1, ctrl_word(1'b1, 1'b0), 32'h0, 1'b0);
        add_entry("tmr ctrl rd", tmr_ctrl, 1'b0, 32'h0, ctrl_word(1'b1, 1'b0), 1'b0);
        run_table();

        bus_transfer("tmr time a", tmr_time, 1'b0, 32'h0, time_a, err);
        check_value("tmr time a err", 32'h0, 32'(err));
        bus_transfer("tmr time b", tmr_time, 1'b0, 32'h0, time_b, err);
        check_value("tmr time b err", 32'h0, 32'(err));
        check_value("tmr time rising", 32'h1, 32'(time_b > time_a));
        check_value("tmr irq idle", 32'h0, 32'(timer_irq));

        add_entry("tmr cmp ahead", tmr_cmp, 1'b1, time_b + 32'd60, 32'h0, 1'b0);
        add_entry("tmr irq enable", tmr_ctrl, 1'b1, ctrl_word(1'b1, 1'b1), 32'h0, 1'b0);
        add_entry("tmr ctrl irq rd", tmr_ctrl, 1'b0, 32'h0, ctrl_word(1'b1, 1'b1), 1'b0);
        run_table();
        check_value("tmr irq early", 32'h0, 32'(timer_irq));
        while (!timer_irq) begin
            @(negedge clock);           // Bounded by the cycle limit
        end

        add_entry("tmr irq disable", tmr_ctrl, 1'b1, ctrl_word(1'b1, 1'b0), 32'h0, 1'b0);
        run_table();
        check_value("tmr irq cleared", 32'h0, 32'(timer_irq));

        check_value("table length", 32'(NUM_ENTRIES), 32'(table_q.size()));
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/soc_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
    parameter int RAM_WORDS = 256,
    parameter int TIME_W    = 32
) (
    input  wire                    clock,
    input  wire                    rst_n_i,
    input  wire                    host_req_i,
    input  wire bus_pkg::bus_req_t host_req_data_i,
    input  wire                    uart_rx_valid_i,
    input  wire [7:0]              uart_rx_ch_i,
    output wire                    host_ack_o,
    output wire bus_pkg::bus_rsp_t host_rsp_o,
    output wire                    uart_tx_valid_o,
    output wire [7:0]              uart_tx_ch_o,
    output wire                    timer_irq_o
);

    wire                          rst_n_sync;
    wire [2:0]                    tgt_req;
    wire [2:0]                    tgt_ack;
    wire bus_pkg::bus_rsp_t [2:0] tgt_rsp;
    wire                          ctrl_en;
    wire                          ctrl_irqen;
    wire [TIME_W-1:0]             cmp;
    wire [TIME_W-1:0]             mtime;

    rst_sync i_rst_sync (
        .clock        (clock),
        .rst_n_i      (rst_n_i),
        .rst_n_sync_o (rst_n_sync)
    );

    bus_decoder i_decoder (
        .clock           (clock),
        .rst_n_i         (rst_n_sync),
        .host_req_i      (host_req_i),
        .host_req_data_i (host_req_data_i),
        .tgt_ack_i       (tgt_ack),
        .tgt_rsp_i       (tgt_rsp),
        .host_ack_o      (host_ack_o),
        .host_rsp_o      (host_rsp_o),
        .tgt_req_o       (tgt_req)
    );

    sim_ram #(.RAM_WORDS(RAM_WORDS)) i_ram (
        .clock      (clock),
        .rst_n_i    (rst_n_sync),
        .req_i      (tgt_req[bus_pkg::TGT_RAM]),
        .req_data_i (host_req_data_i),
        .ack_o      (tgt_ack[bus_pkg::TGT_RAM]),
        .rsp_o      (tgt_rsp[bus_pkg::TGT_RAM])
    );

    uart_port i_uart (
        .clock           (clock),
        .rst_n_i         (rst_n_sync),
        .req_i           (tgt_req[bus_pkg::TGT_UART]),
        .req_data_i      (host_req_data_i),
        .uart_rx_valid_i (uart_rx_valid_i),
        .uart_rx_ch_i    (uart_rx_ch_i),
        .ack_o           (tgt_ack[bus_pkg::TGT_UART]),
        .rsp_o           (tgt_rsp[bus_pkg::TGT_UART]),
        .uart_tx_valid_o (uart_tx_valid_o),
        .uart_tx_ch_o    (uart_tx_ch_o)
    );

    timer_regs #(.TIME_W(TIME_W)) i_timer_regs (
        .clock        (clock),
        .rst_n_i      (rst_n_sync),
        .req_i        (tgt_req[bus_pkg::TGT_TIMER]),
        .req_data_i   (host_req_data_i),
        .mtime_i      (mtime),
        .ack_o        (tgt_ack[bus_pkg::TGT_TIMER]),
        .rsp_o        (tgt_rsp[bus_pkg::TGT_TIMER]),
        .ctrl_en_o    (ctrl_en),
        .ctrl_irqen_o (ctrl_irqen),
        .cmp_o        (cmp)
    );

    timer_counter #(.TIME_W(TIME_W)) i_timer_counter (
        .clock        (clock),
        .rst_n_i      (rst_n_sync),
        .ctrl_en_i    (ctrl_en),
        .ctrl_irqen_i (ctrl_irqen),
        .cmp_i        (cmp),
        .mtime_o      (mtime),
        .irq_o        (timer_irq_o)
    );

endmodule

`default_nettype wire

/* logic/timer_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_counter #(
    parameter int TIME_W = 32
) (
    input  wire              clock,
    input  wire              rst_n_i,
    input  wire              ctrl_en_i,
    input  wire              ctrl_irqen_i,
    input  wire [TIME_W-1:0] cmp_i,
    output logic [TIME_W-1:0] mtime_o,
    output logic              irq_o
);

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_o <= '0;
            irq_o   <= 1'b0;
        end else begin
            if (ctrl_en_i) mtime_o <= mtime_o + 1'b1;
            irq_o <= ctrl_irqen_i && (mtime_o >= cmp_i);    // Level, not edge
        end
    end

endmodule

`default_nettype wire

/* logic/timer_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_regs #(
    parameter int TIME_W = 32
) (
    input  wire                    clock,
    input  wire                    rst_n_i,
    input  wire                    req_i,
    input  wire bus_pkg::bus_req_t req_data_i,
    input  wire [TIME_W-1:0]       mtime_i,
    output logic                   ack_o,
    output bus_pkg::bus_rsp_t      rsp_o,
    output wire                    ctrl_en_o,
    output wire                    ctrl_irqen_o,
    output wire [TIME_W-1:0]       cmp_o
);

    typedef struct packed {
        logic [TIME_W-1:0] cmp;
        logic              irqen;
        logic              en;
    } timer_ctrl_t;

    timer_ctrl_t                ctrl_q;
    logic [bus_pkg::ADDR_W-1:0] ofs;
    logic [bus_pkg::DATA_W-1:0] rd_word;
    logic                       bad;
    logic                       start;

    assign ofs   = req_data_i.addr & ~soc_map_pkg::REGION_MASK;
    assign start = req_i && !ack_o;

    always_comb begin
        rd_word = '0;
        bad     = 1'b0;
        case (ofs)
            soc_map_pkg::TMR_CTRL_OFS: begin
                rd_word[soc_map_pkg::TMR_CTRL_EN_BIT]    = ctrl_q.en;
                rd_word[soc_map_pkg::TMR_CTRL_IRQEN_BIT] = ctrl_q.irqen;
            end
            soc_map_pkg::TMR_CMP_OFS:  rd_word[TIME_W-1:0] = ctrl_q.cmp;
            soc_map_pkg::TMR_TIME_OFS: begin
                rd_word[TIME_W-1:0] = mtime_i;
                bad                 = req_data_i.we;    // Read only
            end
            default: bad = 1'b1;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o  <= 1'b0;
            ctrl_q <= '{cmp: '1, irqen: 1'b0, en: 1'b0};    // Compare parked at max
        end else begin
            ack_o <= req_i;
            if (start && req_data_i.we) begin
                case (ofs)
                    soc_map_pkg::TMR_CTRL_OFS: begin
                        ctrl_q.en    <= req_data_i.wdata[soc_map_pkg::TMR_CTRL_EN_BIT];
                        ctrl_q.irqen <= req_data_i.wdata[soc_map_pkg::TMR_CTRL_IRQEN_BIT];
                    end
                    soc_map_pkg::TMR_CMP_OFS: ctrl_q.cmp <= req_data_i.wdata[TIME_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            rsp_o.rdata <= req_data_i.we ? '0 : rd_word;
            rsp_o.err   <= bad;
        end
    end

    assign ctrl_en_o    = ctrl_q.en;
    assign ctrl_irqen_o = ctrl_q.irqen;
    assign cmp_o        = ctrl_q.cmp;

endmodule

`default_nettype wire

/* logic/uart_port.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_port (
    input  wire                    clock,
    input  wire                    rst_n_i,
    input  wire                    req_i,
    input  wire bus_pkg::bus_req_t req_data_i,
    input  wire                    uart_rx_valid_i,
    input  wire [7:0]              uart_rx_ch_i,
    output logic                   ack_o,
    output bus_pkg::bus_rsp_t      rsp_o,
    output logic                   uart_tx_valid_o,
    output logic [7:0]             uart_tx_ch_o
);

    logic [bus_pkg::ADDR_W-1:0] ofs;
    logic [bus_pkg::DATA_W-1:0] rd_word;
    logic [7:0]                 rx_ch_q;
    logic                       rx_full_q;
    logic                       rx_overrun_q;
    logic                       start;
    logic                       is_data;
    logic                       is_stat;
    logic                       rd_data;
    logic                       rd_stat;
    logic                       wr_data;
    logic                       rx_keep;

    assign ofs     = req_data_i.addr & ~soc_map_pkg::REGION_MASK;
    assign start   = req_i && !ack_o;
    assign is_data = ofs == soc_map_pkg::UART_DATA_OFS;
    assign is_stat = ofs == soc_map_pkg::UART_STAT_OFS;
    assign rd_data = start && !req_data_i.we && is_data;
    assign rd_stat = start && !req_data_i.we && is_stat;
    assign wr_data = start && req_data_i.we && is_data;
    assign rx_keep = rx_full_q && !rd_data;    // Holding register stays occupied

    always_comb begin
        rd_word = '0;
        if (is_data) rd_word[7:0] = rx_ch_q;
        if (is_stat) rd_word[1:0] = {rx_overrun_q, rx_full_q};
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o           <= 1'b0;
            uart_tx_valid_o <= 1'b0;
            rx_full_q       <= 1'b0;
            rx_overrun_q    <= 1'b0;
        end else begin
            ack_o           <= req_i;
            uart_tx_valid_o <= wr_data;    // One pulse per data write
            rx_full_q       <= rx_keep || uart_rx_valid_i;
            if (uart_rx_valid_i && rx_keep) begin
                rx_overrun_q <= 1'b1;      // Character dropped
            end else if (rd_stat) begin
                rx_overrun_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (uart_rx_valid_i && !rx_keep) rx_ch_q <= uart_rx_ch_i;
        if (wr_data) uart_tx_ch_o <= req_data_i.wdata[7:0];
        if (start) begin
            rsp_o.rdata <= req_data_i.we ? '0 : rd_word;
            rsp_o.err   <= !is_data && !is_stat;
        end
    end

    a_tx_single_pulse: assert property (@(posedge clock) disable iff (!rst_n_i)
        uart_tx_valid_o |=> !uart_tx_valid_o);

endmodule

`default_nettype wire

/* logic/sim_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sim_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire                    clock,
    input  wire                    rst_n_i,
    input  wire                    req_i,
    input  wire bus_pkg::bus_req_t req_data_i,
    output logic                   ack_o,
    output bus_pkg::bus_rsp_t      rsp_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [bus_pkg::DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]           idx;
    logic                       start;

    assign idx   = IDX_W'(req_data_i.addr[bus_pkg::ADDR_W-1:2] % RAM_WORDS);    // Wraps
    assign start = req_i && !ack_o;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            if (req_data_i.we) mem[idx] <= req_data_i.wdata;
            rsp_o.rdata <= req_data_i.we ? '0 : mem[idx];
            rsp_o.err   <= 1'b0;
        end
    end

    a_ack_fall_no_req: assert property (@(posedge clock) disable iff (!rst_n_i)
        $fell(ack_o) |-> !req_i);

endmodule

`default_nettype wire

/* logic/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire                          clock,
    input  wire                          rst_n_i,
    input  wire                          host_req_i,
    input  wire bus_pkg::bus_req_t       host_req_data_i,
    input  wire [2:0]                    tgt_ack_i,
    input  wire bus_pkg::bus_rsp_t [2:0] tgt_rsp_i,
    output logic                         host_ack_o,
    output bus_pkg::bus_rsp_t            host_rsp_o,
    output wire [2:0]                    tgt_req_o
);

    logic [bus_pkg::ADDR_W-1:0] region;
    bus_pkg::target_e           addr_tgt;
    bus_pkg::target_e           sel_q;
    bus_pkg::target_e           cur_tgt;
    logic                       active_q;
    logic [3:0]                 req_q;         // Targets plus unmapped responder
    logic                       none_ack_q;
    logic [3:0]                 ack_all;
    bus_pkg::bus_rsp_t          none_rsp;
    bus_pkg::bus_rsp_t          cur_rsp;

    assign region = host_req_data_i.addr & soc_map_pkg::REGION_MASK;

    always_comb begin
        case (region)
            soc_map_pkg::RAM_BASE:   addr_tgt = bus_pkg::TGT_RAM;
            soc_map_pkg::UART_BASE:  addr_tgt = bus_pkg::TGT_UART;
            soc_map_pkg::TIMER_BASE: addr_tgt = bus_pkg::TGT_TIMER;
            default:                 addr_tgt = bus_pkg::TGT_NONE;
        endcase
    end

    assign cur_tgt  = active_q ? sel_q : addr_tgt;    // Choice frozen once started
    assign ack_all  = {none_ack_q, tgt_ack_i};
    assign none_rsp = '{rdata: '0, err: 1'b1};
    assign tgt_req_o = req_q[2:0];

    always_comb begin
        case (sel_q)
            bus_pkg::TGT_RAM:   cur_rsp = tgt_rsp_i[bus_pkg::TGT_RAM];
            bus_pkg::TGT_UART:  cur_rsp = tgt_rsp_i[bus_pkg::TGT_UART];
            bus_pkg::TGT_TIMER: cur_rsp = tgt_rsp_i[bus_pkg::TGT_TIMER];
            default:            cur_rsp = none_rsp;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q      <= bus_pkg::TGT_NONE;
            active_q   <= 1'b0;
            req_q      <= '0;
            none_ack_q <= 1'b0;
            host_ack_o <= 1'b0;
        end else begin
            if (host_req_i && !active_q) begin
                sel_q    <= addr_tgt;
                active_q <= 1'b1;
            end else if (!host_req_i && req_q == '0 && !ack_all[sel_q]) begin
                active_q <= 1'b0;                     // Target ack has fallen
            end
            req_q      <= host_req_i ? (4'b0001 << cur_tgt) : 4'b0000;
            none_ack_q <= req_q[bus_pkg::TGT_NONE];
            host_ack_o <= ack_all[sel_q];
        end
    end

    always_ff @(posedge clock) begin
        host_rsp_o <= cur_rsp;
    end

    // No target sees a request while another still holds its ack
    a_one_target: assert property (@(posedge clock) disable iff (!rst_n_i)
        $onehot0(req_q | ack_all));

    // Ack cannot start without a pending request upstream
    a_ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n_i)
        !host_req_i && !host_ack_o |=> !host_ack_o);

endmodule

`default_nettype wire

/* logic/rst_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_sync (
    input  wire clock,
    input  wire rst_n_i,
    output wire rst_n_sync_o
);

    logic [1:0] sync_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= 2'b00;                  // Assert at once
        end else begin
            sync_q <= {sync_q[0], 1'b1};      // Release after two edges
        end
    end

    assign rst_n_sync_o = sync_q[1];

endmodule

`default_nettype wire

/* logic/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    localparam logic [bus_pkg::ADDR_W-1:0] RAM_BASE    = 32'h8000_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] UART_BASE   = 32'h1000_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] TIMER_BASE  = 32'h0200_0000;
    localparam logic [bus_pkg::ADDR_W-1:0] REGION_MASK = 32'hFFF0_0000;    // Top 12 bits

    localparam logic [bus_pkg::ADDR_W-1:0] UART_DATA_OFS = 32'h0;
    localparam logic [bus_pkg::ADDR_W-1:0] UART_STAT_OFS = 32'h4;

    localparam logic [bus_pkg::ADDR_W-1:0] TMR_CTRL_OFS = 32'h0;
    localparam logic [bus_pkg::ADDR_W-1:0] TMR_CMP_OFS  = 32'h4;
    localparam logic [bus_pkg::ADDR_W-1:0] TMR_TIME_OFS = 32'h8;

    localparam int TMR_CTRL_EN_BIT    = 0;    // Counter runs
    localparam int TMR_CTRL_IRQEN_BIT = 1;    // Compare raises irq

endpackage

`default_nettype wire

/* logic/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // Byte address, word aligned
        logic [DATA_W-1:0] wdata;
        logic              we;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;     // Unmapped address or illegal register
    } bus_rsp_t;

    // Also used as index into the per-target req/ack vectors
    typedef enum logic [1:0] {
        TGT_RAM   = 2'd0,
        TGT_UART  = 2'd1,
        TGT_TIMER = 2'd2,
        TGT_NONE  = 2'd3
    } target_e;

endpackage

`default_nettype wire
